// ==== logic/soc_periph_pkg.sv ====
// APB widths, page map and register offsets shared by the peripheral decoder and register blocks
package soc_periph_pkg;

    // APB bus
    localparam int APB_ADDR_WIDTH = 32;
    localparam int APB_DATA_WIDTH = 32;

    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

    // Page select field, one 4 KiB page per slave
    localparam int PAGE_LSB = 12;
    localparam int PAGE_MSB = 15;

    localparam logic [PAGE_MSB-PAGE_LSB:0] PAGE_GPIO     = 'd0;
    localparam logic [PAGE_MSB-PAGE_LSB:0] PAGE_SOC_CTRL = 'd1;

    // Word offset inside a page
    localparam int REG_OFFSET_LSB = 2;
    localparam int REG_OFFSET_MSB = 5;

    // GPIO
    localparam int NGPIO = 32;

    typedef logic [NGPIO-1:0] gpio_vec_t;

    localparam logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] GPIO_REG_DIR        = 'd0;
    localparam logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] GPIO_REG_OUT        = 'd1;
    localparam logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] GPIO_REG_IN         = 'd2;
    localparam logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] GPIO_REG_INT_EN     = 'd3;
    localparam logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] GPIO_REG_INT_STATUS = 'd4;

    // SoC control
    localparam logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] CTRL_REG_BOOTADDR = 'd0;
    localparam logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] CTRL_REG_FETCHEN  = 'd1;
    localparam logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] CTRL_REG_JTAG     = 'd2;
    localparam logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] CTRL_REG_INFO     = 'd3;

    // Boot from the ROM entry point unless software moves it
    localparam apb_data_t BOOT_ADDR_RESET = 32'h1C00_8080;

    // Version in the upper half, pin count in the lower half
    localparam apb_data_t CHIP_INFO = 32'h0001_0020;

    typedef logic [7:0] jtag_byte_t;

endpackage

// ==== logic/soc_event_pkg.sv ====
// Fabric controller event word layout, imported by the event map and the top level
package soc_event_pkg;

    localparam int FC_EVENT_WIDTH = 32;

    typedef logic [FC_EVENT_WIDTH-1:0] fc_events_t;

    //////////////////////////////
    // Event bit positions
    //////////////////////////////

    // Bits 7:0 stay free for software events

    // DMA processing element
    localparam int EVT_DMA_PE  = 8;
    localparam int EVT_DMA_IRQ = 9;

    // Instruction prefetch
    localparam int EVT_PREFETCH = 12;

    // Either edge of the slow reference clock
    localparam int EVT_REF_CLK = 14;

    // Any enabled GPIO pin change
    localparam int EVT_GPIO = 15;

    // Bits not listed above are reserved and read as zero

endpackage

// ==== logic/apb_periph_decode.sv ====
// APB page decoder, selects one peripheral from the page field and muxes its response back
`timescale 1ns/1ps

module apb_periph_decode
    import soc_periph_pkg::*;
(
    // Master side
    input  apb_addr_t paddr_i,
    input  logic      psel_i,

    // GPIO slave
    output logic      gpio_psel_o,
    input  apb_data_t gpio_prdata_i,
    input  logic      gpio_pready_i,
    input  logic      gpio_pslverr_i,

    // SoC control slave
    output logic      ctrl_psel_o,
    input  apb_data_t ctrl_prdata_i,
    input  logic      ctrl_pready_i,
    input  logic      ctrl_pslverr_i,

    // Response to master
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    logic [PAGE_MSB-PAGE_LSB:0] page;

    assign page = paddr_i[PAGE_MSB:PAGE_LSB];

    //////////////////////////////
    // Select and response mux
    //////////////////////////////

    always_comb begin
        gpio_psel_o = 1'b0;
        ctrl_psel_o = 1'b0;

        // Unmapped page answers on its own, no wait state
        prdata_o  = '0;
        pready_o  = 1'b1;
        pslverr_o = psel_i;

        case (page)
            PAGE_GPIO: begin
                gpio_psel_o = psel_i;
                prdata_o    = gpio_prdata_i;
                pready_o    = gpio_pready_i;
                pslverr_o   = gpio_pslverr_i;
            end
            PAGE_SOC_CTRL: begin
                ctrl_psel_o = psel_i;
                prdata_o    = ctrl_prdata_i;
                pready_o    = ctrl_pready_i;
                pslverr_o   = ctrl_pslverr_i;
            end
            default: begin
                prdata_o = '0;
            end
        endcase
    end

endmodule

// ==== logic/apb_gpio_regs.sv ====
// APB GPIO block with direction, output, synchronized input and per pin change interrupt
`timescale 1ns/1ps

module apb_gpio_regs
    import soc_periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    // APB slave
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,

    // Pins
    input  gpio_vec_t gpio_in_i,
    output gpio_vec_t gpio_out_o,
    output gpio_vec_t gpio_dir_o,

    // One cycle pulse on an enabled pin change
    output logic      gpio_event_o
);

    logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] reg_offset;
    logic      offset_valid;
    logic      wr_en;
    logic      status_rd;

    gpio_vec_t dir_q;
    gpio_vec_t out_q;
    gpio_vec_t int_en_q;
    gpio_vec_t int_status_q;

    gpio_vec_t in_meta_q;
    gpio_vec_t in_sync_q;
    gpio_vec_t in_prev_q;
    gpio_vec_t pin_change;
    logic      event_q;

    assign reg_offset = paddr_i[REG_OFFSET_MSB:REG_OFFSET_LSB];
    assign wr_en      = psel_i & penable_i & pwrite_i & offset_valid;
    assign status_rd  = psel_i & penable_i & ~pwrite_i & (reg_offset == GPIO_REG_INT_STATUS);

    //////////////////////////////
    // Input sync and change detect
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
            in_prev_q <= '0;
        end else begin
            in_meta_q <= gpio_in_i;
            in_sync_q <= in_meta_q;
            in_prev_q <= in_sync_q;
        end
    end

    assign pin_change = (in_sync_q ^ in_prev_q) & int_en_q;

    // New changes win over a clear in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            int_status_q <= '0;
            event_q      <= 1'b0;
        end else begin
            int_status_q <= (int_status_q & ~{NGPIO{status_rd}}) | pin_change;
            event_q      <= |pin_change;
        end
    end

    //////////////////////////////
    // Register writes
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            int_en_q <= '0;
        end else if (wr_en) begin
            case (reg_offset)
                GPIO_REG_DIR:    dir_q    <= pwdata_i;
                GPIO_REG_OUT:    out_q    <= pwdata_i;
                GPIO_REG_INT_EN: int_en_q <= pwdata_i;
                default: ;  // IN and INT_STATUS are read only
            endcase
        end
    end

    // Read mux, always ready
    always_comb begin
        prdata_o     = '0;
        offset_valid = 1'b1;
        case (reg_offset)
            GPIO_REG_DIR:        prdata_o = dir_q;
            GPIO_REG_OUT:        prdata_o = out_q;
            GPIO_REG_IN:         prdata_o = in_sync_q;
            GPIO_REG_INT_EN:     prdata_o = int_en_q;
            GPIO_REG_INT_STATUS: prdata_o = int_status_q;
            default:             offset_valid = 1'b0;
        endcase
    end

    assign pready_o  = psel_i;
    assign pslverr_o = psel_i & ~offset_valid;

    assign gpio_dir_o   = dir_q;
    assign gpio_out_o   = out_q;
    assign gpio_event_o = event_q;

endmodule

// ==== logic/apb_soc_ctrl_regs.sv ====
// APB SoC control block holding boot address, fetch enable, JTAG exchange byte and chip info
`timescale 1ns/1ps

module apb_soc_ctrl_regs
    import soc_periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // APB slave
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,

    // Fabric controller boot
    output apb_data_t  fc_bootaddr_o,
    output logic       fc_fetchen_o,

    // JTAG exchange
    input  jtag_byte_t soc_jtag_reg_i,
    output jtag_byte_t soc_jtag_reg_o
);

    logic [REG_OFFSET_MSB-REG_OFFSET_LSB:0] reg_offset;
    logic       offset_valid;
    logic       wr_en;

    apb_data_t  bootaddr_q;
    logic       fetchen_q;
    jtag_byte_t jtag_q;

    assign reg_offset = paddr_i[REG_OFFSET_MSB:REG_OFFSET_LSB];
    assign wr_en      = psel_i & penable_i & pwrite_i & offset_valid;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bootaddr_q <= BOOT_ADDR_RESET;
            fetchen_q  <= 1'b0;
            jtag_q     <= '0;
        end else if (wr_en) begin
            case (reg_offset)
                CTRL_REG_BOOTADDR: bootaddr_q <= pwdata_i;
                CTRL_REG_FETCHEN:  fetchen_q  <= pwdata_i[0];
                CTRL_REG_JTAG:     jtag_q     <= pwdata_i[7:0];
                default: ;  // Chip info drops writes silently
            endcase
        end
    end

    // JTAG read shows the incoming byte above the outgoing one
    always_comb begin
        prdata_o     = '0;
        offset_valid = 1'b1;
        case (reg_offset)
            CTRL_REG_BOOTADDR: prdata_o = bootaddr_q;
            CTRL_REG_FETCHEN:  prdata_o = {{(APB_DATA_WIDTH-1){1'b0}}, fetchen_q};
            CTRL_REG_JTAG:     prdata_o = {16'h0000, soc_jtag_reg_i, jtag_q};
            CTRL_REG_INFO:     prdata_o = CHIP_INFO;
            default:           offset_valid = 1'b0;
        endcase
    end

    assign pready_o  = psel_i;
    assign pslverr_o = psel_i & ~offset_valid;

    assign fc_bootaddr_o  = bootaddr_q;
    assign fc_fetchen_o   = fetchen_q;
    assign soc_jtag_reg_o = jtag_q;

endmodule

// ==== logic/fc_event_map.sv ====
// Builds the fabric controller event word from direct inputs, GPIO and slow clock edges
`timescale 1ns/1ps

module fc_event_map
    import soc_event_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       slow_clk_i,
    input  logic       dma_pe_evt_i,
    input  logic       dma_pe_irq_i,
    input  logic       pf_evt_i,
    input  logic       gpio_event_i,

    output fc_events_t fc_events_o
);

    logic ref_meta_q;
    logic ref_sync_q;
    logic ref_prev_q;
    logic ref_evt_q;

    //////////////////////////////
    // Slow clock edge detect
    //////////////////////////////

    // Two flop sync, then rise or fall folded into one registered pulse
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ref_meta_q <= 1'b0;
            ref_sync_q <= 1'b0;
            ref_prev_q <= 1'b0;
            ref_evt_q  <= 1'b0;
        end else begin
            ref_meta_q <= slow_clk_i;
            ref_sync_q <= ref_meta_q;
            ref_prev_q <= ref_sync_q;
            ref_evt_q  <= ref_sync_q ^ ref_prev_q;
        end
    end

    // Reserved bits default to zero
    always_comb begin
        fc_events_o              = '0;
        fc_events_o[EVT_DMA_PE]  = dma_pe_evt_i;
        fc_events_o[EVT_DMA_IRQ] = dma_pe_irq_i;
        fc_events_o[EVT_PREFETCH] = pf_evt_i;
        fc_events_o[EVT_REF_CLK] = ref_evt_q;
        fc_events_o[EVT_GPIO]    = gpio_event_i;
    end

endmodule

// ==== logic/soc_periph_top.sv ====
// Peripheral subsystem top, one APB slave port fanned out to GPIO and SoC control plus event map
`timescale 1ns/1ps

module soc_periph_top
    import soc_periph_pkg::*;
    import soc_event_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // APB slave port
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    input  logic       pwrite_i,
    input  logic       psel_i,
    input  logic       penable_i,
    output apb_data_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,

    // GPIO pins
    input  gpio_vec_t  gpio_in_i,
    output gpio_vec_t  gpio_out_o,
    output gpio_vec_t  gpio_dir_o,

    // SoC control
    input  jtag_byte_t soc_jtag_reg_i,
    output apb_data_t  fc_bootaddr_o,
    output logic       fc_fetchen_o,
    output jtag_byte_t soc_jtag_reg_o,

    // Events
    input  logic       slow_clk_i,
    input  logic       dma_pe_evt_i,
    input  logic       dma_pe_irq_i,
    input  logic       pf_evt_i,
    output fc_events_t fc_events_o
);

    logic      gpio_psel;
    apb_data_t gpio_prdata;
    logic      gpio_pready;
    logic      gpio_pslverr;
    logic      gpio_event;

    logic      ctrl_psel;
    apb_data_t ctrl_prdata;
    logic      ctrl_pready;
    logic      ctrl_pslverr;

    //////////////////////////////
    // APB page decode
    //////////////////////////////

    apb_periph_decode i_decode (
        .paddr_i        ( paddr_i      ),
        .psel_i         ( psel_i       ),
        .gpio_psel_o    ( gpio_psel    ),
        .gpio_prdata_i  ( gpio_prdata  ),
        .gpio_pready_i  ( gpio_pready  ),
        .gpio_pslverr_i ( gpio_pslverr ),
        .ctrl_psel_o    ( ctrl_psel    ),
        .ctrl_prdata_i  ( ctrl_prdata  ),
        .ctrl_pready_i  ( ctrl_pready  ),
        .ctrl_pslverr_i ( ctrl_pslverr ),
        .prdata_o       ( prdata_o     ),
        .pready_o       ( pready_o     ),
        .pslverr_o      ( pslverr_o    )
    );

    //////////////////////////////
    // Register blocks
    //////////////////////////////

    // Address, data, direction and enable are shared by both slaves
    apb_gpio_regs i_gpio (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .psel_i       ( gpio_psel    ),
        .penable_i    ( penable_i    ),
        .pwrite_i     ( pwrite_i     ),
        .paddr_i      ( paddr_i      ),
        .pwdata_i     ( pwdata_i     ),
        .prdata_o     ( gpio_prdata  ),
        .pready_o     ( gpio_pready  ),
        .pslverr_o    ( gpio_pslverr ),
        .gpio_in_i    ( gpio_in_i    ),
        .gpio_out_o   ( gpio_out_o   ),
        .gpio_dir_o   ( gpio_dir_o   ),
        .gpio_event_o ( gpio_event   )
    );

    apb_soc_ctrl_regs i_soc_ctrl (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .psel_i         ( ctrl_psel      ),
        .penable_i      ( penable_i      ),
        .pwrite_i       ( pwrite_i       ),
        .paddr_i        ( paddr_i        ),
        .pwdata_i       ( pwdata_i       ),
        .prdata_o       ( ctrl_prdata    ),
        .pready_o       ( ctrl_pready    ),
        .pslverr_o      ( ctrl_pslverr   ),
        .fc_bootaddr_o  ( fc_bootaddr_o  ),
        .fc_fetchen_o   ( fc_fetchen_o   ),
        .soc_jtag_reg_i ( soc_jtag_reg_i ),
        .soc_jtag_reg_o ( soc_jtag_reg_o )
    );

    // FC event word
    fc_event_map i_event_map (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .slow_clk_i   ( slow_clk_i   ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .gpio_event_i ( gpio_event   ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

// ==== testbench/tb_soc_periph.sv ====
// Directed testbench for the peripheral subsystem, drives APB and pins and checks every response
`timescale 1ns/1ps

module tb_soc_periph
    import soc_periph_pkg::*;
    import soc_event_pkg::*;
;

    localparam int APB_TIMEOUT   = 8;
    localparam int EVENT_TIMEOUT = 10;
    localparam int POLL_TIMEOUT  = 8;

    // Bits that carry a defined event, everything else must read zero
    localparam fc_events_t USED_EVENTS = fc_events_t'((32'd1 << EVT_DMA_PE) |
        (32'd1 << EVT_DMA_IRQ) | (32'd1 << EVT_PREFETCH) |
        (32'd1 << EVT_REF_CLK) | (32'd1 << EVT_GPIO));

    logic       clk_i;
    logic       rst_n_i;
    apb_addr_t  paddr_i;
    apb_data_t  pwdata_i;
    logic       pwrite_i;
    logic       psel_i;
    logic       penable_i;
    apb_data_t  prdata_o;
    logic       pready_o;
    logic       pslverr_o;
    gpio_vec_t  gpio_in_i;
    gpio_vec_t  gpio_out_o;
    gpio_vec_t  gpio_dir_o;
    jtag_byte_t soc_jtag_reg_i;
    apb_data_t  fc_bootaddr_o;
    logic       fc_fetchen_o;
    jtag_byte_t soc_jtag_reg_o;
    logic       slow_clk_i;
    logic       dma_pe_evt_i;
    logic       dma_pe_irq_i;
    logic       pf_evt_i;
    fc_events_t fc_events_o;

    int check_errors;
    int timeout_errors;

    soc_periph_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_gpio(input string name, input gpio_vec_t exp, input gpio_vec_t act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_events(input string name, input fc_events_t exp,
                                input fc_events_t act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            check_errors++;
        end
    endtask

    //////////////////////////////
    // APB master
    //////////////////////////////

    function automatic apb_addr_t reg_addr(input logic [3:0] page, input logic [3:0] offset);
        apb_addr_t addr;
        addr = '0;
        addr[PAGE_MSB:PAGE_LSB] = page;
        addr[REG_OFFSET_MSB:REG_OFFSET_LSB] = offset;
        return addr;
    endfunction

    // Setup cycle, then access cycle until pready, response sampled before the completing edge
    task automatic apb_access(input apb_addr_t addr, input logic write, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        int   waited;
        logic done;
        @(negedge clk_i);
        paddr_i   = addr;
        pwrite_i  = write;
        pwdata_i  = wdata;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(negedge clk_i);
        penable_i = 1'b1;
        waited = 0;
        done   = 1'b0;
        rdata  = '0;
        err    = 1'b1;
        while (!done && waited < APB_TIMEOUT) begin
            #1;
            // Slaves never stall, so the first access cycle must complete
            if (waited == 0) begin
                check_bit("pready_o first access cycle", 1'b1, pready_o);
            end
            if (pready_o) begin
                rdata = prdata_o;
                err   = pslverr_o;
                done  = 1'b1;
            end else begin
                waited++;
                @(negedge clk_i);
            end
        end
        if (!done) begin
            $display("Timeout at %0t: pready never rose for APB access to %h", $time, addr);
            timeout_errors++;
        end
        @(posedge clk_i);
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused_rdata;
        apb_access(addr, 1'b1, data, unused_rdata, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_access(addr, 1'b0, '0, data, err);
    endtask

    // Watches one event bit until it pulses, then demands a quiet word afterwards
    task automatic expect_single_pulse(input string name, input int bit_pos);
        int         waited;
        logic       found;
        fc_events_t exp;
        waited = 0;
        found  = 1'b0;
        exp    = '0;
        exp[bit_pos] = 1'b1;
        while (!found && waited < EVENT_TIMEOUT) begin
            @(negedge clk_i);
            #1;
            if (fc_events_o[bit_pos]) begin
                found = 1'b1;
                check_events({name, " pulse word"}, exp, fc_events_o);
            end
            waited++;
        end
        if (!found) begin
            $display("Timeout at %0t: no %s pulse on the event word", $time, name);
            timeout_errors++;
        end
        repeat (6) begin
            @(negedge clk_i);
            #1;
            check_events({name, " after pulse"}, '0, fc_events_o);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_soc_ctrl();
        apb_data_t  rdata;
        apb_data_t  boot;
        jtag_byte_t jtag_out;
        apb_data_t  rnd;
        logic       err;
        check_data("fc_bootaddr_o after reset", BOOT_ADDR_RESET, fc_bootaddr_o);
        check_bit("fc_fetchen_o after reset", 1'b0, fc_fetchen_o);
        boot = $urandom;
        apb_write(reg_addr(PAGE_SOC_CTRL, CTRL_REG_BOOTADDR), boot, err);
        check_bit("pslverr_o bootaddr write", 1'b0, err);
        apb_read(reg_addr(PAGE_SOC_CTRL, CTRL_REG_BOOTADDR), rdata, err);
        check_data("bootaddr readback", boot, rdata);
        check_data("fc_bootaddr_o", boot, fc_bootaddr_o);
        apb_write(reg_addr(PAGE_SOC_CTRL, CTRL_REG_FETCHEN), 32'h1, err);
        check_bit("fc_fetchen_o", 1'b1, fc_fetchen_o);
        apb_read(reg_addr(PAGE_SOC_CTRL, CTRL_REG_FETCHEN), rdata, err);
        check_data("fetchen readback", 32'h1, rdata);
        rnd = $urandom;
        soc_jtag_reg_i = rnd[15:8];
        jtag_out = rnd[7:0];
        apb_write(reg_addr(PAGE_SOC_CTRL, CTRL_REG_JTAG), {24'h0, jtag_out}, err);
        check_data("soc_jtag_reg_o", {24'h0, jtag_out}, {24'h0, soc_jtag_reg_o});
        apb_read(reg_addr(PAGE_SOC_CTRL, CTRL_REG_JTAG), rdata, err);
        check_data("jtag readback", {16'h0, rnd[15:8], jtag_out}, rdata);
        apb_read(reg_addr(PAGE_SOC_CTRL, CTRL_REG_INFO), rdata, err);
        check_data("chip info", CHIP_INFO, rdata);
        check_bit("pslverr_o chip info read", 1'b0, err);
    endtask

    task automatic test_gpio_regs();
        gpio_vec_t dir;
        gpio_vec_t out;
        apb_data_t rdata;
        logic      err;
        int        polls;
        dir = $urandom;
        out = $urandom;
        apb_write(reg_addr(PAGE_GPIO, GPIO_REG_DIR), dir, err);
        apb_write(reg_addr(PAGE_GPIO, GPIO_REG_OUT), out, err);
        check_gpio("gpio_dir_o", dir, gpio_dir_o);
        check_gpio("gpio_out_o", out, gpio_out_o);
        apb_read(reg_addr(PAGE_GPIO, GPIO_REG_DIR), rdata, err);
        check_gpio("dir readback", dir, rdata);
        apb_read(reg_addr(PAGE_GPIO, GPIO_REG_OUT), rdata, err);
        check_gpio("out readback", out, rdata);
        @(negedge clk_i);
        gpio_in_i = $urandom;
        polls = 0;
        rdata = ~gpio_in_i;
        while (rdata !== gpio_in_i && polls < POLL_TIMEOUT) begin
            apb_read(reg_addr(PAGE_GPIO, GPIO_REG_IN), rdata, err);
            polls++;
        end
        if (rdata !== gpio_in_i) begin
            $display("Timeout at %0t: input register never showed the driven pins", $time);
            timeout_errors++;
        end
    endtask

    task automatic test_gpio_interrupt();
        gpio_vec_t mask;
        gpio_vec_t exp;
        apb_data_t rdata;
        logic      err;
        int        en_pin;
        int        dis_pin;
        en_pin  = $urandom % NGPIO;
        dis_pin = (en_pin + 1 + ($urandom % (NGPIO - 1))) % NGPIO;
        mask = $urandom;
        mask[en_pin]  = 1'b1;
        mask[dis_pin] = 1'b0;
        apb_write(reg_addr(PAGE_GPIO, GPIO_REG_INT_EN), mask, err);
        apb_read(reg_addr(PAGE_GPIO, GPIO_REG_INT_STATUS), rdata, err);
        check_gpio("int status before toggle", '0, rdata);
        @(negedge clk_i);
        gpio_in_i[en_pin]  = ~gpio_in_i[en_pin];
        gpio_in_i[dis_pin] = ~gpio_in_i[dis_pin];
        expect_single_pulse("EVT_GPIO", EVT_GPIO);
        exp = '0;
        exp[en_pin] = 1'b1;
        apb_read(reg_addr(PAGE_GPIO, GPIO_REG_INT_STATUS), rdata, err);
        check_gpio("int status", exp, rdata);
        apb_read(reg_addr(PAGE_GPIO, GPIO_REG_INT_STATUS), rdata, err);
        check_gpio("int status after clear", '0, rdata);
    endtask

    task automatic test_errors();
        gpio_vec_t  dir;
        gpio_vec_t  out;
        apb_data_t  boot;
        logic       fetchen;
        jtag_byte_t jtag;
        apb_data_t  int_en;
        apb_data_t  rdata;
        logic       err;
        dir     = gpio_dir_o;
        out     = gpio_out_o;
        boot    = fc_bootaddr_o;
        fetchen = fc_fetchen_o;
        jtag    = soc_jtag_reg_o;
        apb_read(reg_addr(PAGE_GPIO, GPIO_REG_INT_EN), int_en, err);
        apb_read(reg_addr(4'd5, 4'd0), rdata, err);
        check_bit("pslverr_o unmapped page read", 1'b1, err);
        check_data("prdata_o unmapped page read", '0, rdata);
        apb_write(reg_addr(4'd5, 4'd0), $urandom, err);
        check_bit("pslverr_o unmapped page write", 1'b1, err);
        apb_read(reg_addr(PAGE_GPIO, 4'd7), rdata, err);
        check_bit("pslverr_o gpio unmapped offset", 1'b1, err);
        check_data("prdata_o gpio unmapped offset", '0, rdata);
        apb_read(reg_addr(PAGE_SOC_CTRL, 4'd9), rdata, err);
        check_bit("pslverr_o ctrl unmapped offset", 1'b1, err);
        apb_write(reg_addr(PAGE_GPIO, 4'd7), $urandom, err);
        check_bit("pslverr_o gpio unmapped write", 1'b1, err);
        apb_write(reg_addr(PAGE_SOC_CTRL, 4'd9), $urandom, err);
        check_bit("pslverr_o ctrl unmapped write", 1'b1, err);
        apb_write(reg_addr(PAGE_SOC_CTRL, CTRL_REG_INFO), $urandom, err);
        check_bit("pslverr_o chip info write", 1'b0, err);
        check_gpio("gpio_dir_o unchanged", dir, gpio_dir_o);
        check_gpio("gpio_out_o unchanged", out, gpio_out_o);
        check_data("fc_bootaddr_o unchanged", boot, fc_bootaddr_o);
        check_bit("fc_fetchen_o unchanged", fetchen, fc_fetchen_o);
        check_data("soc_jtag_reg_o unchanged", {24'h0, jtag}, {24'h0, soc_jtag_reg_o});
        apb_read(reg_addr(PAGE_GPIO, GPIO_REG_INT_EN), rdata, err);
        check_data("int enable unchanged", int_en, rdata);
        apb_read(reg_addr(PAGE_SOC_CTRL, CTRL_REG_INFO), rdata, err);
        check_data("chip info unchanged", CHIP_INFO, rdata);
    endtask

    task automatic test_event_map();
        fc_events_t exp;
        int         sel;
        for (sel = 0; sel < 3; sel++) begin
            @(negedge clk_i);
            dma_pe_evt_i = (sel == 0);
            dma_pe_irq_i = (sel == 1);
            pf_evt_i     = (sel == 2);
            exp = '0;
            case (sel)
                0:       exp[EVT_DMA_PE]   = 1'b1;
                1:       exp[EVT_DMA_IRQ]  = 1'b1;
                default: exp[EVT_PREFETCH] = 1'b1;
            endcase
            #1;
            check_events("fc_events_o direct event", exp, fc_events_o);
            @(negedge clk_i);
            dma_pe_evt_i = 1'b0;
            dma_pe_irq_i = 1'b0;
            pf_evt_i     = 1'b0;
            #1;
            check_events("fc_events_o direct event cleared", '0, fc_events_o);
        end
        // Rising edge first, then falling edge
        repeat (2) begin
            @(negedge clk_i);
            slow_clk_i = ~slow_clk_i;
            expect_single_pulse("EVT_REF_CLK", EVT_REF_CLK);
        end
    endtask

    // Reserved event bits are watched for the whole run after reset
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            #2;
            check_events("fc_events_o reserved bits", '0, fc_events_o & ~USED_EVENTS);
        end
    end

    initial begin
        apb_data_t seed_draw;
        check_errors   = 0;
        timeout_errors = 0;
        seed_draw      = $urandom(32'h9aaf_7401);
        rst_n_i        = 1'b0;
        paddr_i        = '0;
        pwdata_i       = '0;
        pwrite_i       = 1'b0;
        psel_i         = 1'b0;
        penable_i      = 1'b0;
        gpio_in_i      = '0;
        soc_jtag_reg_i = '0;
        slow_clk_i     = 1'b0;
        dma_pe_evt_i   = 1'b0;
        dma_pe_irq_i   = 1'b0;
        pf_evt_i       = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        test_soc_ctrl();
        test_gpio_regs();
        test_gpio_interrupt();
        test_errors();
        test_event_map();

        repeat (2) @(negedge clk_i);
        $display("Errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/soc_periph_pkg.sv
logic/soc_event_pkg.sv
logic/apb_periph_decode.sv
logic/apb_gpio_regs.sv
logic/apb_soc_ctrl_regs.sv
logic/fc_event_map.sv
logic/soc_periph_top.sv
testbench/tb_soc_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module tb_soc_periph \
    -f compile.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
